/* dv/tc_checker.sv */
`timescale 1ns/1ps

module tc_checker (
    input  logic                             clk_i,
    input  logic                             chk_i,        // row carries expectations
    input  int                               row_i,        // row number for messages
    input  logic [tc_reg_pkg::TC_DATA_W-1:0] rdata_i,      // DUT read data
    input  logic                             irq_i,        // DUT interrupt
    input  logic [tc_reg_pkg::TC_DATA_W-1:0] exp_rdata_i,
    input  logic                             exp_irq_i,
    output int                               checks_o,
    output int                               errors_o
);

    int checks = 0;
    int errors = 0;

    //////////////////////////////
    // compare at the falling edge
    //////////////////////////////
    // inputs change on the rising edge, so mid cycle everything has settled
    always @(negedge clk_i) begin
        if (chk_i) begin
            checks = checks + 1;
            if (rdata_i !== exp_rdata_i) begin
                errors = errors + 1;
                $display("MISMATCH %0t: row %0d rdata_o 0x%08h, expected 0x%08h",
                         $time, row_i, rdata_i, exp_rdata_i);
            end
            if (irq_i !== exp_irq_i) begin
                errors = errors + 1;
                $display("MISMATCH %0t: row %0d irq_o %b, expected %b",
                         $time, row_i, irq_i, exp_irq_i);
            end
        end
    end

    assign checks_o = checks;
    assign errors_o = errors;  // read by the testbench at the end

endmodule

/* dv/tc_tb.sv */
`timescale 1ns/1ps

module tc_tb;
    import tc_reg_pkg::*;
    import tc_fsm_pkg::*;

    localparam int SEED       = 94970;
    localparam int N_PERIODIC = 3;  // random periodic trials

    // one table row, applied on one rising edge
    typedef struct packed {
        logic                 we;
        logic [TC_ADDR_W-1:0] addr;
        logic [TC_DATA_W-1:0] data;
        logic [TC_DATA_W-1:0] exp_rdata;
        logic                 exp_irq;
        logic                 chk;  // 0 on write rows
    } row_t;

    logic                 start;
    logic                 rst_n;
    logic                 we;
    logic [TC_ADDR_W-1:0] addr;
    logic [TC_DATA_W-1:0] wdata;
    logic [TC_DATA_W-1:0] rdata;
    logic                 irq;
    logic [TC_DATA_W-1:0] exp_rdata;  // expectations travel to the checker
    logic                 exp_irq;
    logic                 chk;
    int                   row_id;
    int                   checks;
    int                   mismatches;
    int                   timeouts;
    row_t                 table_q[$];

    always #10 start = ~start;  // 20 ns

    tc_top u_tc_top (
        .start_i (start),
        .rst_n_i (rst_n),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .rdata_o (rdata),
        .irq_o   (irq)
    );

    tc_checker u_checker (
        .clk_i       (start),
        .chk_i       (chk),
        .row_i       (row_id),
        .rdata_i     (rdata),
        .irq_i       (irq),
        .exp_rdata_i (exp_rdata),
        .exp_irq_i   (exp_irq),
        .checks_o    (checks),
        .errors_o    (mismatches)
    );

    // CTRL word from its fields: mask bit 3, mode 2:1, enable 0
    function automatic logic [31:0] ctrl_word(input logic mask, input tc_mode_e mode,
                                              input logic en);
        return {28'd0, mask, mode, en};
    endfunction

    // periodic COUNT j cycles after the first load, period p+2
    function automatic logic [31:0] periodic_count(input int p, input int j);
        int m;
        m = j % (p + 2);
        if (m <= p) begin
            return p - m;
        end
        return 0;  // extra cycle at zero while the FSM sits in LOAD
    endfunction

    function automatic row_t make_row(input logic w, input logic [TC_ADDR_W-1:0] a,
                                      input logic [31:0] d, input logic [31:0] e,
                                      input logic ei, input logic c);
        row_t r;
        r.we        = w;
        r.addr      = a;
        r.data      = d;
        r.exp_rdata = e;
        r.exp_irq   = ei;
        r.chk       = c;
        return r;
    endfunction

    function automatic void add_row(input logic w, input logic [TC_ADDR_W-1:0] a,
                                    input logic [31:0] d, input logic [31:0] e,
                                    input logic ei, input logic c);
        table_q.push_back(make_row(w, a, d, e, ei, c));
    endfunction

    task automatic apply_row(input row_t r, input int id);
        @(posedge start);
        we        <= r.we;
        addr      <= r.addr;
        wdata     <= r.data;
        exp_rdata <= r.exp_rdata;
        exp_irq   <= r.exp_irq;
        chk       <= r.chk;
        row_id    <= id;
    endtask

    // idle cycles until irq_o is seen high, bounded by limit
    task automatic wait_for_irq(input int limit, input int id);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            apply_row(make_row(1'b0, TC_REG_CNT, 32'h0, 32'h0, 1'b0, 1'b0), id);
            @(negedge start);
            seen = (irq === 1'b1);
            n    = n + 1;
        end
        if (!seen) begin
            timeouts = timeouts + 1;
            $display("ERROR at %0t: irq_o did not rise within %0d cycles", $time, limit);
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////
    // columns: we, addr, wdata, expected rdata, expected irq, check
    task automatic build_table();
        logic [31:0] os_irq;
        logic [31:0] os_off;
        logic [31:0] os_quiet;
        logic [31:0] per_on;
        int          p;
        int          t;
        int          j;
        os_irq   = ctrl_word(1'b1, TC_MODE_ONESHOT, 1'b1);
        os_off   = ctrl_word(1'b1, TC_MODE_ONESHOT, 1'b0);
        os_quiet = ctrl_word(1'b0, TC_MODE_ONESHOT, 1'b1);  // mask clear
        per_on   = ctrl_word(1'b1, TC_MODE_PERIODIC, 1'b1);
        // reset values
        add_row(1'b0, TC_REG_CTRL, 32'h0, 32'h0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_PST, 32'h0, 32'h0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'h0, 1'b0, 1'b1);
        add_row(1'b0, 2'd3, 32'h0, 32'h0, 1'b0, 1'b1);
        // register access, only bits 3:0 of CTRL stick
        add_row(1'b1, TC_REG_CTRL, 32'h1234_5678, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CTRL, 32'h0, 32'h8, 1'b0, 1'b1);
        add_row(1'b1, TC_REG_PST, 32'ha5c3_0f96, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_PST, 32'h0, 32'ha5c3_0f96, 1'b0, 1'b1);
        add_row(1'b1, TC_REG_CNT, 32'hdead_beef, 32'h0, 1'b0, 1'b0);  // read only
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'h0, 1'b0, 1'b1);
        add_row(1'b1, 2'd3, 32'hffff_ffff, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, 2'd3, 32'h0, 32'h0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CTRL, 32'h0, 32'h8, 1'b0, 1'b1);
        // one-shot, preset 3, load lands three rows after the enable write
        add_row(1'b1, TC_REG_PST, 32'd3, 32'h0, 1'b0, 1'b0);
        add_row(1'b1, TC_REG_CTRL, os_irq, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);  // FSM still IDLE
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);  // LOAD
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd3, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd2, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd1, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b1, 1'b1);  // DONE, irq up
        add_row(1'b0, TC_REG_CTRL, 32'h0, os_irq, 1'b1, 1'b1);
        // disable from DONE, irq follows one cycle behind the bit
        add_row(1'b1, TC_REG_CTRL, os_off, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b1, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        // same countdown with the mask clear
        add_row(1'b1, TC_REG_CTRL, os_quiet, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd3, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd2, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd1, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);  // DONE, irq held off
        // disable mid count, then re-enable
        add_row(1'b1, TC_REG_CTRL, 32'h0, 32'h0, 1'b0, 1'b0);
        add_row(1'b1, TC_REG_PST, 32'd10, 32'h0, 1'b0, 1'b0);
        add_row(1'b1, TC_REG_CTRL, os_irq, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd0, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd10, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd9, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd8, 1'b0, 1'b1);
        add_row(1'b1, TC_REG_CTRL, os_off, 32'h0, 1'b0, 1'b0);    // count is 7 here
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd6, 1'b0, 1'b1);      // still RUN
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd5, 1'b0, 1'b1);      // last decrement
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd5, 1'b0, 1'b1);      // frozen
        add_row(1'b0, TC_REG_CTRL, 32'h0, os_off, 1'b0, 1'b1);
        add_row(1'b1, TC_REG_CTRL, os_irq, 32'h0, 1'b0, 1'b0);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd5, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd5, 1'b0, 1'b1);
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd10, 1'b0, 1'b1);    // reloaded
        add_row(1'b0, TC_REG_CNT, 32'h0, 32'd9, 1'b0, 1'b1);
        //////////////////////////////
        // periodic trials, random preset 4..20
        //////////////////////////////
        for (t = 0; t < N_PERIODIC; t++) begin
            p = 4 + ($urandom % 17);
            add_row(1'b1, TC_REG_CTRL, 32'h0, 32'h0, 1'b0, 1'b0);
            add_row(1'b1, TC_REG_PST, p, 32'h0, 1'b0, 1'b0);
            add_row(1'b1, TC_REG_CTRL, per_on, 32'h0, 1'b0, 1'b0);  // mask set on purpose
            add_row(1'b0, TC_REG_CTRL, 32'h0, per_on, 1'b0, 1'b1);
            add_row(1'b0, TC_REG_CTRL, 32'h0, per_on, 1'b0, 1'b1);
            for (j = 0; j < 3 * (p + 2); j++) begin
                add_row(1'b0, TC_REG_CNT, 32'h0, periodic_count(p, j), 1'b0, 1'b1);
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int          i;
        int          id;
        int          p;
        logic [31:0] os_irq;
        start      = 1'b0;
        rst_n      = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        exp_rdata  = '0;
        exp_irq    = 1'b0;
        chk        = 1'b0;
        row_id     = 0;
        timeouts   = 0;
        os_irq     = ctrl_word(1'b1, TC_MODE_ONESHOT, 1'b1);
        void'($urandom(SEED));
        build_table();

        repeat (3) @(posedge start);
        rst_n <= 1'b1;

        for (i = 0; i < table_q.size(); i++) begin
            apply_row(table_q[i], i);
        end

        // one-shot with a random preset, irq found by polling
        id = table_q.size();
        p  = 4 + ($urandom % 17);
        apply_row(make_row(1'b1, TC_REG_CTRL, 32'h0, 32'h0, 1'b0, 1'b0), id);
        apply_row(make_row(1'b1, TC_REG_PST, p, 32'h0, 1'b0, 1'b0), id + 1);
        apply_row(make_row(1'b1, TC_REG_CTRL, os_irq, 32'h0, 1'b0, 1'b0), id + 2);
        wait_for_irq(p + 8, id + 3);  // rise expected after p+4 cycles
        apply_row(make_row(1'b0, TC_REG_CNT, 32'h0, 32'h0, 1'b1, 1'b1), id + 4);
        apply_row(make_row(1'b0, TC_REG_CTRL, 32'h0, os_irq, 1'b1, 1'b1), id + 5);
        apply_row(make_row(1'b0, TC_REG_CNT, 32'h0, 32'h0, 1'b0, 1'b0), id + 6);
        repeat (2) @(posedge start);  // let the last check land

        $display("checks: %0d  mismatches: %0d  timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0 && checks > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* hdl/tc_cnt_if.sv */
`timescale 1ns/1ps

interface tc_cnt_if;
    import tc_reg_pkg::*;

    logic                 load;    // fsm -> counter, one cycle pulse
    logic                 dec;     // fsm -> counter, held while running
    logic [TC_DATA_W-1:0] preset;  // regs -> counter
    logic [TC_DATA_W-1:0] count;   // counter -> regs for readback
    logic                 zero;    // counter -> fsm

    // sequencing side
    modport fsm (
        output load,
        output dec,
        input  zero
    );

    // the down counter itself
    modport cnt (
        input  load,
        input  dec,
        input  preset,
        output count,
        output zero
    );

    // register block supplies preset, reads count back
    modport regs (
        output preset,
        input  count
    );

endinterface

/* hdl/tc_counter.sv */
`timescale 1ns/1ps

module tc_counter (
    input  logic  start_i,
    input  logic  rst_n_i,
    tc_cnt_if.cnt cnt_if
);
    import tc_reg_pkg::*;

    logic [TC_DATA_W-1:0] count_q;  // visible as COUNT

    //////////////////////////////
    // down counter
    //////////////////////////////
    always_ff @(posedge start_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (cnt_if.load) begin
            count_q <= cnt_if.preset;       // load has priority
        end else if (cnt_if.dec) begin
            count_q <= count_q - 1'b1;
        end
        // otherwise hold, covers IDLE freeze and DONE
    end

    assign cnt_if.count = count_q;
    assign cnt_if.zero  = (count_q == '0);  // combinational flag for the FSM

    //////////////////////////////
    // checks
    //////////////////////////////
    // relies on the FSM gating dec with zero
    a_no_wrap: assert property (
        @(posedge start_i) disable iff (!rst_n_i)
        (count_q == '0 && !cnt_if.load) |=> (count_q == '0)
    ) else $error("counter wrapped below zero");

endmodule

/* hdl/tc_ctrl_fsm.sv */
`timescale 1ns/1ps

module tc_ctrl_fsm (
    input  logic                 start_i,
    input  logic                 rst_n_i,
    input  tc_reg_pkg::tc_ctrl_t ctrl_i,
    tc_cnt_if.fsm                cnt_if,
    output logic                 irq_o
);
    import tc_fsm_pkg::*;

    tc_state_e state_q;
    tc_state_e state_d;
    logic      periodic;  // mode 1 selected
    logic      irq_q;

    // anything other than the periodic code acts as one-shot
    assign periodic = (ctrl_i.mode == TC_MODE_PERIODIC);

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            TC_IDLE: begin
                if (ctrl_i.enable) begin
                    state_d = TC_LOAD;  // enable seen one edge ago
                end
            end
            TC_LOAD: begin
                state_d = TC_RUN;  // counter takes preset on this edge
            end
            TC_RUN: begin
                if (cnt_if.zero) begin
                    // reload costs LOAD plus one RUN cycle at zero
                    state_d = periodic ? TC_LOAD : TC_DONE;
                end
            end
            TC_DONE: begin
                state_d = TC_DONE;  // parked until enable drops
            end
            default: state_d = TC_IDLE;
        endcase

        // disable wins from any state
        if (!ctrl_i.enable) begin
            state_d = TC_IDLE;
        end
    end

    //////////////////////////////
    // state and irq registers
    //////////////////////////////
    always_ff @(posedge start_i) begin
        if (!rst_n_i) begin
            state_q <= TC_IDLE;
            irq_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            irq_q   <= (state_d == TC_DONE) && ctrl_i.irq_mask;  // level, tracks mask
        end
    end

    // counter strobes, decoded from current state
    assign cnt_if.load = (state_q == TC_LOAD);
    assign cnt_if.dec  = (state_q == TC_RUN) && !cnt_if.zero;  // stop at zero
    assign irq_o       = irq_q;

    //////////////////////////////
    // checks
    //////////////////////////////
    // one-shot parks only once the counter really sits at zero
    a_done_at_zero: assert property (
        @(posedge start_i) disable iff (!rst_n_i)
        (state_q == TC_DONE) |-> cnt_if.zero
    ) else $error("DONE reached with a nonzero count");

endmodule

/* hdl/tc_fsm_pkg.sv */
package tc_fsm_pkg;

    //////////////////////////////
    // counting modes
    //////////////////////////////
    // only two codes defined
    // 2 and 3 fall through to one-shot handling in the FSM
    typedef enum logic [1:0] {
        TC_MODE_ONESHOT  = 2'd0,  // count to zero, stop, irq
        TC_MODE_PERIODIC = 2'd1   // reload on zero, no irq
    } tc_mode_e;

    //////////////////////////////
    // control FSM states
    //////////////////////////////
    typedef enum logic [1:0] {
        TC_IDLE = 2'd0,  // disabled, count frozen
        TC_LOAD = 2'd1,  // one cycle, copy preset into counter
        TC_RUN  = 2'd2,  // decrement until zero
        TC_DONE = 2'd3   // one-shot finished, irq may be up
    } tc_state_e;

endpackage

/* hdl/tc_reg_pkg.sv */
package tc_reg_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////
    localparam int TC_DATA_W = 32;  // register and bus width
    localparam int TC_ADDR_W = 2;   // four word slots

    // register map, slot 3 is unmapped and reads zero
    localparam logic [TC_ADDR_W-1:0] TC_REG_CTRL = 2'd0;
    localparam logic [TC_ADDR_W-1:0] TC_REG_PST  = 2'd1;  // reload value
    localparam logic [TC_ADDR_W-1:0] TC_REG_CNT  = 2'd2;  // read only

    // bits of CTRL that actually exist in hardware
    localparam logic [TC_DATA_W-1:0] TC_CTRL_MASK = 32'h0000_000f;

    //////////////////////////////
    // CTRL word layout
    //////////////////////////////
    // msb first, so enable lands in bit 0
    typedef struct packed {
        logic [TC_DATA_W-5:0]  reserved;  // always zero on read
        logic                  irq_mask;  // bit 3
        tc_fsm_pkg::tc_mode_e  mode;      // bits 2:1
        logic                  enable;    // bit 0
    } tc_ctrl_t;

    // same 32 bits seen as a bus word or as fields
    typedef union packed {
        logic [TC_DATA_W-1:0] raw;     // as it travels on wdata/rdata
        tc_ctrl_t             fields;  // as the FSM consumes it
    } tc_ctrl_u;

endpackage

/* hdl/tc_regs.sv */
`timescale 1ns/1ps

module tc_regs (
    input  logic                             start_i,
    input  logic                             rst_n_i,
    input  logic                             we_i,
    input  logic [tc_reg_pkg::TC_ADDR_W-1:0] addr_i,
    input  logic [tc_reg_pkg::TC_DATA_W-1:0] wdata_i,
    output logic [tc_reg_pkg::TC_DATA_W-1:0] rdata_o,
    output tc_reg_pkg::tc_ctrl_t             ctrl_o,
    tc_cnt_if.regs                           cnt_if
);
    import tc_reg_pkg::*;
    import tc_fsm_pkg::*;

    // implemented CTRL bits only, nothing stored for the reserved field
    logic                 irq_mask_q;
    tc_mode_e             mode_q;
    logic                 enable_q;
    logic [TC_DATA_W-1:0] preset_q;  // PRESET, written whole

    tc_ctrl_u wr_u;  // incoming write data split into fields
    tc_ctrl_u rd_u;  // CTRL rebuilt for readback and for the FSM

    logic we_ctrl;
    logic we_pst;

    //////////////////////////////
    // write decode
    //////////////////////////////
    assign we_ctrl = we_i && (addr_i == TC_REG_CTRL);
    assign we_pst  = we_i && (addr_i == TC_REG_PST);
    // COUNT and slot 3 have no write enable at all

    always_comb begin
        wr_u.raw = wdata_i;
    end

    always_ff @(posedge start_i) begin
        if (!rst_n_i) begin
            irq_mask_q <= 1'b0;
            mode_q     <= TC_MODE_ONESHOT;
            enable_q   <= 1'b0;
            preset_q   <= '0;
        end else begin
            if (we_ctrl) begin
                irq_mask_q <= wr_u.fields.irq_mask;
                mode_q     <= wr_u.fields.mode;      // codes 2/3 kept as written
                enable_q   <= wr_u.fields.enable;
                // upper wdata bits dropped here
            end
            if (we_pst) begin
                preset_q <= wdata_i;  // picked up at next LOAD
            end
        end
    end

    //////////////////////////////
    // CTRL rebuild and readback
    //////////////////////////////
    always_comb begin
        rd_u.raw             = '0;  // reserved bits read as zero
        rd_u.fields.irq_mask = irq_mask_q;
        rd_u.fields.mode     = mode_q;
        rd_u.fields.enable   = enable_q;
    end

    assign ctrl_o        = rd_u.fields;  // straight to the FSM
    assign cnt_if.preset = preset_q;

    // read mux, purely combinational so a write shows on the next cycle
    always_comb begin
        case (addr_i)
            TC_REG_CTRL: rdata_o = rd_u.raw;
            TC_REG_PST:  rdata_o = preset_q;
            TC_REG_CNT:  rdata_o = cnt_if.count;  // live counter value
            default:     rdata_o = '0;            // unmapped slot
        endcase
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    // a CTRL write reads back as the written word with only the mask bits kept
    a_ctrl_wr_masked: assert property (
        @(posedge start_i) disable iff (!rst_n_i)
        we_ctrl |=> (rd_u.raw == ($past(wdata_i) & TC_CTRL_MASK))
    ) else $error("CTRL readback differs from masked write data");

endmodule

/* hdl/tc_top.sv */
`timescale 1ns/1ps

module tc_top (
    input  logic                             start_i,
    input  logic                             rst_n_i,
    input  logic                             we_i,
    input  logic [tc_reg_pkg::TC_ADDR_W-1:0] addr_i,
    input  logic [tc_reg_pkg::TC_DATA_W-1:0] wdata_i,
    output logic [tc_reg_pkg::TC_DATA_W-1:0] rdata_o,
    output logic                             irq_o
);
    import tc_reg_pkg::*;

    tc_ctrl_t ctrl;  // decoded CTRL, regs to fsm

    // load/dec/preset/count/zero bundle
    tc_cnt_if u_cnt_if ();

    //////////////////////////////
    // register block
    //////////////////////////////
    tc_regs u_regs (
        .start_i (start_i),
        .rst_n_i (rst_n_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ctrl_o  (ctrl),
        .cnt_if  (u_cnt_if.regs)
    );

    //////////////////////////////
    // sequencing
    //////////////////////////////
    tc_ctrl_fsm u_fsm (
        .start_i (start_i),
        .rst_n_i (rst_n_i),
        .ctrl_i  (ctrl),
        .cnt_if  (u_cnt_if.fsm),
        .irq_o   (irq_o)      // straight out, no extra stage
    );

    tc_counter u_counter (
        .start_i (start_i),
        .rst_n_i (rst_n_i),
        .cnt_if  (u_cnt_if.cnt)
    );

endmodule

/* list.f */
hdl/tc_fsm_pkg.sv
hdl/tc_reg_pkg.sv
hdl/tc_cnt_if.sv
hdl/tc_regs.sv
hdl/tc_ctrl_fsm.sv
hdl/tc_counter.sv
hdl/tc_top.sv
dv/tc_checker.sv
dv/tc_tb.sv
